//--- design/output_arbiter.sv
module output_arbiter (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [router_pkg::NUM_PORTS-1:0] request,
  input  logic                             accept,
  output logic [router_pkg::NUM_PORTS-1:0] grant
);
  import router_pkg::*;

  port_e pointer;
  port_e winner;
  port_e after_winner;
  logic  found;

  // Search the requests starting at the pointer and wrapping around,
  // the first one found wins
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = pointer;
    for (int i = 0; i < NUM_PORTS; i++) begin
      idx = int'(pointer) + i;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (!found && request[idx]) begin
        found  = 1'b1;
        winner = port_e'(idx);
      end
    end
  end

  // Nothing is granted while the output register cannot take a flit
  always_comb begin
    grant = '0;
    if (found && accept) begin
      grant[winner] = 1'b1;
    end
  end

  assign after_winner = (winner == PORT_SN) ? PORT_CW : port_e'(winner + 3'd1);

  // The winner drops to the lowest priority for the next round
  always_ff @(posedge clk) begin
    if (reset) begin
      pointer <= PORT_CW;
    end else if (|grant) begin
      pointer <= after_winner;
    end
  end

endmodule

//--- design/route_compute.sv
module route_compute (
  input  logic                             valid,
  input  logic [router_pkg::FLIT_W-1:0]    flit,
  output logic [router_pkg::NUM_PORTS-1:0] request
);
  import router_pkg::*;

  logic [HOP_W-1:0] x_hops;
  logic [HOP_W-1:0] y_hops;
  logic             ew_dir;
  logic             ns_dir;
  port_e            target;

  assign x_hops = flit[X_HOP_LSB +: HOP_W];
  assign y_hops = flit[Y_HOP_LSB +: HOP_W];
  assign ew_dir = flit[EW_DIR_BIT];
  assign ns_dir = flit[NS_DIR_BIT];

  // Dimension order routing
  // X hops are used up first, then Y hops, then the flit is delivered locally
  always_comb begin
    if (x_hops != '0) begin
      if (ew_dir == WEST_TO_EAST) begin
        target = PORT_CW;
      end else begin
        target = PORT_CCW;
      end
    end else if (y_hops != '0) begin
      if (ns_dir == NORTH_TO_SOUTH) begin
        target = PORT_NS;
      end else begin
        target = PORT_SN;
      end
    end else begin
      target = PORT_PE;
    end
  end

  // One request bit at most, and none while the buffer is empty
  always_comb begin
    request         = '0;
    request[target] = valid;
  end

endmodule

//--- design/router.sv
module router (
  input  logic                          clk,
  input  logic                          reset,

  // Clockwise channel
  input  logic                          cw_rx_send,
  input  logic [router_pkg::FLIT_W-1:0] cw_rx_data,
  output logic                          cw_rx_ready,
  output logic                          cw_tx_send,
  output logic [router_pkg::FLIT_W-1:0] cw_tx_data,
  input  logic                          cw_tx_ready,

  // Counter clockwise channel
  input  logic                          ccw_rx_send,
  input  logic [router_pkg::FLIT_W-1:0] ccw_rx_data,
  output logic                          ccw_rx_ready,
  output logic                          ccw_tx_send,
  output logic [router_pkg::FLIT_W-1:0] ccw_tx_data,
  input  logic                          ccw_tx_ready,

  // Processing element channel
  input  logic                          pe_rx_send,
  input  logic [router_pkg::FLIT_W-1:0] pe_rx_data,
  output logic                          pe_rx_ready,
  output logic                          pe_tx_send,
  output logic [router_pkg::FLIT_W-1:0] pe_tx_data,
  input  logic                          pe_tx_ready,

  // North to south channel
  input  logic                          ns_rx_send,
  input  logic [router_pkg::FLIT_W-1:0] ns_rx_data,
  output logic                          ns_rx_ready,
  output logic                          ns_tx_send,
  output logic [router_pkg::FLIT_W-1:0] ns_tx_data,
  input  logic                          ns_tx_ready,

  // South to north channel
  input  logic                          sn_rx_send,
  input  logic [router_pkg::FLIT_W-1:0] sn_rx_data,
  output logic                          sn_rx_ready,
  output logic                          sn_tx_send,
  output logic [router_pkg::FLIT_W-1:0] sn_tx_data,
  input  logic                          sn_tx_ready
);
  import router_pkg::*;

  logic [NUM_PORTS-1:0]             rx_send;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] rx_data;
  logic [NUM_PORTS-1:0]             rx_ready;
  logic [NUM_PORTS-1:0]             tx_send;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] tx_data;
  logic [NUM_PORTS-1:0]             tx_ready;

  logic [NUM_PORTS-1:0]             in_valid;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] in_flit;
  logic [NUM_PORTS-1:0]             out_accept;

  // Rows are indexed by input port and columns by output port
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_row;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_col;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_row;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_col;

  assign rx_send[PORT_CW]  = cw_rx_send;
  assign rx_send[PORT_CCW] = ccw_rx_send;
  assign rx_send[PORT_PE]  = pe_rx_send;
  assign rx_send[PORT_NS]  = ns_rx_send;
  assign rx_send[PORT_SN]  = sn_rx_send;

  assign rx_data[PORT_CW]  = cw_rx_data;
  assign rx_data[PORT_CCW] = ccw_rx_data;
  assign rx_data[PORT_PE]  = pe_rx_data;
  assign rx_data[PORT_NS]  = ns_rx_data;
  assign rx_data[PORT_SN]  = sn_rx_data;

  assign cw_rx_ready  = rx_ready[PORT_CW];
  assign ccw_rx_ready = rx_ready[PORT_CCW];
  assign pe_rx_ready  = rx_ready[PORT_PE];
  assign ns_rx_ready  = rx_ready[PORT_NS];
  assign sn_rx_ready  = rx_ready[PORT_SN];

  assign cw_tx_send  = tx_send[PORT_CW];
  assign ccw_tx_send = tx_send[PORT_CCW];
  assign pe_tx_send  = tx_send[PORT_PE];
  assign ns_tx_send  = tx_send[PORT_NS];
  assign sn_tx_send  = tx_send[PORT_SN];

  assign cw_tx_data  = tx_data[PORT_CW];
  assign ccw_tx_data = tx_data[PORT_CCW];
  assign pe_tx_data  = tx_data[PORT_PE];
  assign ns_tx_data  = tx_data[PORT_NS];
  assign sn_tx_data  = tx_data[PORT_SN];

  assign tx_ready[PORT_CW]  = cw_tx_ready;
  assign tx_ready[PORT_CCW] = ccw_tx_ready;
  assign tx_ready[PORT_PE]  = pe_tx_ready;
  assign tx_ready[PORT_NS]  = ns_tx_ready;
  assign tx_ready[PORT_SN]  = sn_tx_ready;

  // Requests go from input rows to arbiter columns, grants come back the other way
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_row
    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_col
      assign req_col[j][i]   = req_row[i][j];
      assign grant_row[i][j] = grant_col[j][i];
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    router_input_buffer u_input_buffer (
      .clk   (clk),
      .reset (reset),
      .send  (rx_send[p]),
      .data  (rx_data[p]),
      .ready (rx_ready[p]),
      .grant (grant_row[p]),
      .valid (in_valid[p]),
      .flit  (in_flit[p])
    );

    route_compute u_route_compute (
      .valid   (in_valid[p]),
      .flit    (in_flit[p]),
      .request (req_row[p])
    );

    output_arbiter u_output_arbiter (
      .clk     (clk),
      .reset   (reset),
      .request (req_col[p]),
      .accept  (out_accept[p]),
      .grant   (grant_col[p])
    );

    router_output_port #(
      .OUT_PORT (port_e'(p))
    ) u_output_port (
      .clk    (clk),
      .reset  (reset),
      .grant  (grant_col[p]),
      .flits  (in_flit),
      .accept (out_accept[p]),
      .send   (tx_send[p]),
      .data   (tx_data[p]),
      .ready  (tx_ready[p])
    );
  end

endmodule

//--- design/router_input_buffer.sv
module router_input_buffer (
  input  logic                             clk,
  input  logic                             reset,

  // Upstream send/ready channel
  input  logic                             send,
  input  logic [router_pkg::FLIT_W-1:0]    data,
  output logic                             ready,

  // Grants from the five output arbiters, one bit per output
  input  logic [router_pkg::NUM_PORTS-1:0] grant,

  // Held flit towards route compute and the output ports
  output logic                             valid,
  output logic [router_pkg::FLIT_W-1:0]    flit
);
  import router_pkg::*;

  logic leaving;
  logic load;

  // A grant from any output means the held flit is taken this cycle
  assign leaving = valid && (|grant);

  // The slot is free if it is empty or its flit leaves on this edge,
  // which lets a new flit follow every cycle
  assign ready = !valid || leaving;
  assign load  = send && ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (leaving) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      flit <= data;
    end
  end

endmodule

//--- design/router_output_port.sv
module router_output_port #(
  parameter router_pkg::port_e OUT_PORT = router_pkg::PORT_PE
) (
  input  logic                                                   clk,
  input  logic                                                   reset,

  // Grant column from this port's arbiter and the flits of all inputs
  input  logic [router_pkg::NUM_PORTS-1:0]                       grant,
  input  logic [router_pkg::NUM_PORTS-1:0][router_pkg::FLIT_W-1:0] flits,
  output logic                                                   accept,

  // Downstream send/ready channel
  output logic                                                   send,
  output logic [router_pkg::FLIT_W-1:0]                          data,
  input  logic                                                   ready
);
  import router_pkg::*;

  logic [FLIT_W-1:0] selected;
  logic [FLIT_W-1:0] updated;
  logic              load;

  // The register can take a new flit if it is empty or is drained this cycle
  assign accept = !send || ready;
  assign load   = |grant;

  // Grants are one-hot, so an OR of the masked flits picks the winner
  always_comb begin
    selected = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      selected = selected | (flits[i] & {FLIT_W{grant[i]}});
    end
  end

  // One hop is used up on the axis this port moves along
  always_comb begin
    updated = selected;
    case (OUT_PORT)
      PORT_CW, PORT_CCW: begin
        updated[X_HOP_LSB +: HOP_W] = selected[X_HOP_LSB +: HOP_W] - HOP_W'(1);
      end
      PORT_NS, PORT_SN: begin
        updated[Y_HOP_LSB +: HOP_W] = selected[Y_HOP_LSB +: HOP_W] - HOP_W'(1);
      end
      default: begin
        // Local delivery leaves the flit untouched
        updated = selected;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      send <= 1'b0;
    end else if (load) begin
      send <= 1'b1;
    end else if (ready) begin
      send <= 1'b0;
    end
  end

  // Data stays stable while send is high and ready is low
  always_ff @(posedge clk) begin
    if (load) begin
      data <= updated;
    end
  end

endmodule

//--- design/router_pkg.sv
package router_pkg;

  // Flit and router dimensions
  localparam int FLIT_W    = 64;
  localparam int NUM_PORTS = 5;
  localparam int HOP_W     = 4;
  localparam int PAYLOAD_W = 32;

  // Header bit positions
  // Bit 63 is not used by the router and is carried through as is
  localparam int NS_DIR_BIT = 62;
  localparam int EW_DIR_BIT = 61;
  localparam int Y_HOP_LSB  = 52;
  localparam int X_HOP_LSB  = 48;

  // Values of the two direction bits
  localparam logic NORTH_TO_SOUTH = 1'b0;
  localparam logic SOUTH_TO_NORTH = 1'b1;
  localparam logic EAST_TO_WEST   = 1'b0;
  localparam logic WEST_TO_EAST   = 1'b1;

  // Router ports
  // The encoding indexes every request and grant vector and sets the
  // round-robin order of the arbiters
  typedef enum logic [2:0] {
    PORT_CW  = 3'd0,
    PORT_CCW = 3'd1,
    PORT_PE  = 3'd2,
    PORT_NS  = 3'd3,
    PORT_SN  = 3'd4
  } port_e;

endpackage

//--- router.f
design/router_pkg.sv
design/router_input_buffer.sv
design/route_compute.sv
design/output_arbiter.sv
design/router_output_port.sv
design/router.sv
tests/router_tb.sv

//--- tests/router_tb.sv
module router_tb;
  import router_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int FLITS_PER_PORT = 8;
  localparam int STREAM_LEN     = 8;
  localparam int WAIT_CYCLES    = 20;
  localparam int TEST_FLITS     = NUM_PORTS * FLITS_PER_PORT + NUM_PORTS + 2 + 3 + STREAM_LEN;

  logic clk;
  logic reset;

  logic [NUM_PORTS-1:0]             rx_send;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] rx_data;
  logic [NUM_PORTS-1:0]             tx_ready;
  wire  [NUM_PORTS-1:0]             rx_ready;
  wire  [NUM_PORTS-1:0]             tx_send;
  wire  [NUM_PORTS-1:0][FLIT_W-1:0] tx_data;

  int errors;
  int tests_passed;
  int tests_failed;

  router dut (
    .clk          (clk),
    .reset        (reset),
    .cw_rx_send   (rx_send[PORT_CW]),
    .cw_rx_data   (rx_data[PORT_CW]),
    .cw_rx_ready  (rx_ready[PORT_CW]),
    .cw_tx_send   (tx_send[PORT_CW]),
    .cw_tx_data   (tx_data[PORT_CW]),
    .cw_tx_ready  (tx_ready[PORT_CW]),
    .ccw_rx_send  (rx_send[PORT_CCW]),
    .ccw_rx_data  (rx_data[PORT_CCW]),
    .ccw_rx_ready (rx_ready[PORT_CCW]),
    .ccw_tx_send  (tx_send[PORT_CCW]),
    .ccw_tx_data  (tx_data[PORT_CCW]),
    .ccw_tx_ready (tx_ready[PORT_CCW]),
    .pe_rx_send   (rx_send[PORT_PE]),
    .pe_rx_data   (rx_data[PORT_PE]),
    .pe_rx_ready  (rx_ready[PORT_PE]),
    .pe_tx_send   (tx_send[PORT_PE]),
    .pe_tx_data   (tx_data[PORT_PE]),
    .pe_tx_ready  (tx_ready[PORT_PE]),
    .ns_rx_send   (rx_send[PORT_NS]),
    .ns_rx_data   (rx_data[PORT_NS]),
    .ns_rx_ready  (rx_ready[PORT_NS]),
    .ns_tx_send   (tx_send[PORT_NS]),
    .ns_tx_data   (tx_data[PORT_NS]),
    .ns_tx_ready  (tx_ready[PORT_NS]),
    .sn_rx_send   (rx_send[PORT_SN]),
    .sn_rx_data   (rx_data[PORT_SN]),
    .sn_rx_ready  (rx_ready[PORT_SN]),
    .sn_tx_send   (tx_send[PORT_SN]),
    .sn_tx_data   (tx_data[PORT_SN]),
    .sn_tx_ready  (tx_ready[PORT_SN])
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic string port_name(input int p);
    case (p)
      PORT_CW:  return "cw";
      PORT_CCW: return "ccw";
      PORT_PE:  return "pe";
      PORT_NS:  return "ns";
      default:  return "sn";
    endcase
  endfunction

  // Random source fields, payload and spare bits around the given header
  function automatic logic [FLIT_W-1:0] make_flit(input logic ns_dir, input logic ew_dir,
                                                  input logic [HOP_W-1:0] y_hops,
                                                  input logic [HOP_W-1:0] x_hops);
    logic [FLIT_W-1:0] f;
    f = {$urandom, $urandom};
    f[NS_DIR_BIT]             = ns_dir;
    f[EW_DIR_BIT]             = ew_dir;
    f[Y_HOP_LSB +: HOP_W]     = y_hops;
    f[X_HOP_LSB +: HOP_W]     = x_hops;
    return f;
  endfunction

  // X hops first, then Y hops, then local delivery
  function automatic int expect_port(input logic [FLIT_W-1:0] f);
    if (f[X_HOP_LSB +: HOP_W] != 0) begin
      return (f[EW_DIR_BIT] == WEST_TO_EAST) ? PORT_CW : PORT_CCW;
    end
    if (f[Y_HOP_LSB +: HOP_W] != 0) begin
      return (f[NS_DIR_BIT] == NORTH_TO_SOUTH) ? PORT_NS : PORT_SN;
    end
    return PORT_PE;
  endfunction

  function automatic logic [FLIT_W-1:0] expect_flit(input logic [FLIT_W-1:0] f);
    logic [FLIT_W-1:0] r;
    int                p;
    r = f;
    p = expect_port(f);
    if (p == PORT_CW || p == PORT_CCW) begin
      r[X_HOP_LSB +: HOP_W] = f[X_HOP_LSB +: HOP_W] - 1;
    end else if (p == PORT_NS || p == PORT_SN) begin
      r[Y_HOP_LSB +: HOP_W] = f[Y_HOP_LSB +: HOP_W] - 1;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [FLIT_W-1:0] got,
                             input logic [FLIT_W-1:0] expected);
    if (got !== expected) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  // Every task below starts and ends just after a falling edge
  task automatic send_flit(input int port, input logic [FLIT_W-1:0] flit);
    int cycles;
    cycles        = 0;
    rx_send[port] = 1'b1;
    rx_data[port] = flit;
    #1;
    while (!rx_ready[port] && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!rx_ready[port]) begin
      $display("Input %s was not ready for %0d cycles", port_name(port), WAIT_CYCLES);
      errors++;
    end else begin
      @(posedge clk);
    end
    @(negedge clk);
    rx_send[port] = 1'b0;
  endtask

  task automatic receive_flit(input int port, input logic [FLIT_W-1:0] expected);
    logic                 done;
    int                   cycles;
    logic [NUM_PORTS-1:0] others;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      #1;
      others = tx_send & ~(NUM_PORTS'(1) << port);
      if (tx_send[port]) begin
        check_value({port_name(port), "_tx_data"}, tx_data[port], expected);
        @(posedge clk);
        @(negedge clk);
        done = 1'b1;
      end else if (others != 0) begin
        $display("A flit meant for %s came out on another port (tx_send %b)",
                 port_name(port), tx_send);
        errors++;
        @(negedge clk);
        done = 1'b1;
      end else if (cycles == WAIT_CYCLES) begin
        $display("No flit came out on %s within %0d cycles", port_name(port), WAIT_CYCLES);
        errors++;
        done = 1'b1;
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset_state();
    int start;
    start = errors;
    #1;
    check_value("tx_send", tx_send, '0);
    check_value("rx_ready", rx_ready, {NUM_PORTS{1'b1}});
    @(negedge clk);
    finish_test("reset_state", start);
  endtask

  // Runs while every arbiter pointer is still at cw
  task automatic test_contention();
    int                start;
    logic [FLIT_W-1:0] from_cw;
    logic [FLIT_W-1:0] from_sn;
    start   = errors;
    from_cw = make_flit(1'b0, 1'b0, '0, '0);
    from_sn = make_flit(1'b1, 1'b1, '0, '0);
    fork
      send_flit(PORT_CW, from_cw);
      send_flit(PORT_SN, from_sn);
    join
    receive_flit(PORT_PE, from_cw);
    receive_flit(PORT_PE, from_sn);
    finish_test("contention", start);
  endtask

  task automatic test_routing();
    int                start;
    logic [FLIT_W-1:0] f;
    logic [HOP_W-1:0]  x_hops;
    logic [HOP_W-1:0]  y_hops;
    start = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < FLITS_PER_PORT; k++) begin
        // Bits of k pick the axes and the direction so that each input reaches every output
        x_hops = k[2] ? HOP_W'($urandom_range(3, 1)) : '0;
        y_hops = k[1] ? HOP_W'($urandom_range(3, 1)) : '0;
        f = make_flit(k[0], k[0], y_hops, x_hops);
        send_flit(p, f);
        receive_flit(expect_port(f), expect_flit(f));
      end
    end
    finish_test("routing", start);
  endtask

  task automatic test_local_delivery();
    int                start;
    logic [FLIT_W-1:0] f;
    start = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      f = make_flit(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), '0, '0);
      send_flit(p, f);
      receive_flit(PORT_PE, f);
    end
    finish_test("local_delivery", start);
  endtask

  task automatic test_back_pressure();
    int                start;
    logic [FLIT_W-1:0] f [3];
    start = errors;
    for (int i = 0; i < 3; i++) begin
      f[i] = make_flit(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), '0, '0);
    end
    tx_ready[PORT_PE] = 1'b0;
    send_flit(PORT_CW, f[0]);
    send_flit(PORT_CW, f[1]);
    // First flit parked at pe, second one fills the cw buffer
    repeat (4) begin
      #1;
      check_value("pe_tx_send", tx_send[PORT_PE], 1'b1);
      check_value("pe_tx_data", tx_data[PORT_PE], f[0]);
      check_value("cw_rx_ready", rx_ready[PORT_CW], 1'b0);
      @(negedge clk);
    end
    tx_ready[PORT_PE] = 1'b1;
    fork
      send_flit(PORT_CW, f[2]);
      begin
        for (int i = 0; i < 3; i++) begin
          receive_flit(PORT_PE, f[i]);
        end
      end
    join
    finish_test("back_pressure", start);
  endtask

  task automatic test_streaming();
    int                start;
    logic [FLIT_W-1:0] f [STREAM_LEN];
    start = errors;
    for (int i = 0; i < STREAM_LEN; i++) begin
      f[i] = make_flit(1'($urandom_range(1, 0)), EAST_TO_WEST,
                       HOP_W'($urandom_range(15, 0)), HOP_W'(1 + i));
    end
    fork
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          send_flit(PORT_NS, f[i]);
        end
      end
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          receive_flit(PORT_CCW, expect_flit(f[i]));
        end
      end
    join
    finish_test("streaming", start);
  endtask

  initial begin
    #(TEST_FLITS * 20 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    rx_send      = '0;
    rx_data      = '0;
    tx_ready     = '1;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'h80c2_d19b));
    repeat (2) @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_contention();
    test_routing();
    test_local_delivery();
    test_back_pressure();
    test_streaming();

    $display("summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
